// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the uart testbench with verilator and runs it into sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_uart -f sources.f -o tb_uart
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_uart > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
   exit 1
fi
exit 0

// ==== sources.f ====
+incdir+.
uart_pkg.sv
uart_bit_timer.sv
uart_tx.sv
uart_rx.sv
uart_core.sv
uart_props.sv
uart_checker.sv
tb_uart.sv

// ==== tb_uart.sv ====
//////////////////////////////
// uart core testbench, random bytes through both directions
//////////////////////////////
`timescale 1ns/1ps

module tb_uart;

   import uart_pkg::*;

   localparam int BIT_CYC = 16;
   localparam int FRAMES  = 44;                     // 20 tx, 20 rx, 4 in the short tests
   localparam int LIMIT   = FRAMES * 12 * BIT_CYC + 200;

   logic       clk = 1'b0;
   logic       arst_n;
   uart_ctrl_t ctrl;
   logic [7:0] tx_data, rx_data, b, exp_tx_data, exp_rx_data;
   logic       write, read, rxd, cts, tx_ready, rx_ready;
   logic       exp_tx_valid, exp_rx_valid, test_done, all_done;
   uart_pins_t pins;
   int         seed, test_id, misc_errs, err_count;
   int         cycles = 0;

   always #4 clk = ~clk;

   uart_core DUT (
      .clk_i(clk), .arst_n_i(arst_n), .ctrl_i(ctrl), .tx_data_i(tx_data),
      .data_write_en_i(write), .data_read_en_i(read), .rs232_rxd_i(rxd),
      .rs232_cts_i(cts), .rx_data_o(rx_data), .tx_ready_o(tx_ready),
      .rx_ready_o(rx_ready), .pins_o(pins)
   );

   uart_checker chk (
      .clk_i(clk), .arst_n_i(arst_n), .ctrl_i(ctrl), .rs232_cts_i(cts),
      .data_read_en_i(read), .rx_data_i(rx_data), .tx_ready_i(tx_ready),
      .rx_ready_i(rx_ready), .pins_i(pins), .exp_tx_valid_i(exp_tx_valid),
      .exp_tx_data_i(exp_tx_data), .exp_rx_valid_i(exp_rx_valid),
      .exp_rx_data_i(exp_rx_data), .test_id_i(test_id), .test_done_i(test_done),
      .all_done_i(all_done), .misc_errs_i(misc_errs), .err_count_o(err_count)
   );

   task automatic step(input int n = 1);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_tx_level(input logic lvl, input string what);
      int i;
      for (i = 0; i < 400 && tx_ready !== lvl; i++) step();
      if (tx_ready !== lvl) begin
         $display("timed out waiting for %s", what);
         misc_errs++;
      end
   endtask

   task automatic read_byte();
      int i;
      for (i = 0; i < 400 && rx_ready !== 1'b1; i++) step();
      if (rx_ready !== 1'b1) begin
         $display("timed out waiting for rx_ready");
         misc_errs++;
      end
      read = 1'b1;
      step();
      read = 1'b0;
   endtask

   task automatic write_byte(input logic [7:0] d);
      tx_data      = d;
      write        = 1'b1;
      exp_tx_data  = d;
      exp_tx_valid = 1'b1;
      step();
      write        = 1'b0;
      exp_tx_valid = 1'b0;
   endtask

   // line model, one 8N1 frame onto rxd
   task automatic send_frame(input logic [7:0] d);
      logic [9:0] bits;
      int         i;
      bits         = {1'b1, d, 1'b0};
      exp_rx_data  = d;
      exp_rx_valid = 1'b1;
      step();
      exp_rx_valid = 1'b0;
      for (i = 0; i < 10; i++) begin
         rxd = bits[i];
         step(BIT_CYC);
      end
   endtask

   task automatic end_test();
      test_done = 1'b1;
      step();
      test_done = 1'b0;
      test_id++;
   endtask

   //////////////////////////////
   // test sequence
   //////////////////////////////
   initial begin
      seed = 32'h9b90;
      arst_n = 1'b0;
      ctrl = '0;
      ctrl.bit_duration = 16'(BIT_CYC);
      {tx_data, exp_tx_data, exp_rx_data} = '0;
      {write, read, cts, exp_tx_valid, exp_rx_valid, test_done, all_done} = '0;
      rxd = 1'b1;
      test_id = 0;
      misc_errs = 0;
      step(8);
      arst_n = 1'b1;
      step(4);
      ctrl.tx_en = 1'b1;
      ctrl.rx_en = 1'b1;
      cts = 1'b1;
      wait_tx_level(1'b1, "tx_ready after enable");
      step(2 * BIT_CYC);                            // receiver sees a full idle bit
      end_test();
      repeat (20) begin
         b = 8'($random(seed));
         write_byte(b);
         wait_tx_level(1'b1, "tx_ready after frame");
      end
      end_test();
      repeat (20) begin
         b = 8'($random(seed));
         send_frame(b);
         read_byte();
      end
      end_test();
      cts = 1'b0;                                   // flow control
      step(4);
      b = 8'($random(seed));
      write_byte(b);
      step(40);
      cts = 1'b1;
      wait_tx_level(1'b0, "frame start after cts");
      wait_tx_level(1'b1, "tx_ready after frame");
      end_test();
      rxd = 1'b0;                                   // glitch shorter than half a bit
      step(4);
      rxd = 1'b1;
      step(3 * BIT_CYC);
      b = 8'($random(seed));
      send_frame(b);
      read_byte();
      end_test();
      b = 8'($random(seed));
      write_byte(b);
      step(5 * BIT_CYC);
      ctrl.soft_rst = 1'b1;
      step();
      ctrl.soft_rst = 1'b0;
      wait_tx_level(1'b1, "tx_ready after soft reset");
      b = 8'($random(seed));
      write_byte(b);
      wait_tx_level(1'b1, "tx_ready after frame");
      end_test();
      all_done = 1'b1;
      step();
      if (err_count == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= LIMIT) begin
         $display("timeout, run went past %0d cycles without finishing", LIMIT);
         $display("=== FAIL ===");
         $finish;
      end
   end

endmodule

// ==== uart_bit_timer.sv ====
//////////////////////////////
// bit timer for one direction of the uart
// marks the full-bit and half-bit points of the running count
//////////////////////////////
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_bit_timer (
   input  logic                   clk_i,
   input  logic                   arst_n_i,
   input  logic                   soft_rst_i,
   input  uart_pkg::timer_ctl_t   ctl_i,
   input  logic [`UART_DIV_W-1:0] bit_duration_i,
   output logic                   bit_done_o,
   output logic                   half_done_o
);

   logic [`UART_DIV_W-1:0] cnt_q;
   logic [`UART_DIV_W-1:0] half_dur;

   //////////////////////////////
   // cycle counter
   //////////////////////////////
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt_q <= '0;
      end else if (soft_rst_i) begin
         cnt_q <= '0;
      end else if (ctl_i.clr) begin
         cnt_q <= `UART_DIV_W'(1);            // first cycle of a bit
      end else if (ctl_i.run) begin
         cnt_q <= cnt_q + `UART_DIV_W'(1);
      end
   end

   //////////////////////////////
   // bit points
   //////////////////////////////
   assign half_dur = bit_duration_i >> 1;  // rounded down

   // both flags are levels, they hold while the count is parked
   assign bit_done_o  = (cnt_q == bit_duration_i);
   assign half_done_o = (cnt_q == half_dur);

endmodule

// ==== uart_checker.sv ====
//////////////////////////////
// watches the uart ports, decodes txd frames and compares with expected bytes
//////////////////////////////
`timescale 1ns/1ps

module uart_checker (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  uart_pkg::uart_ctrl_t ctrl_i,
   input  logic                 rs232_cts_i,
   input  logic                 data_read_en_i,
   input  logic [7:0]           rx_data_i,
   input  logic                 tx_ready_i,
   input  logic                 rx_ready_i,
   input  uart_pkg::uart_pins_t pins_i,
   input  logic                 exp_tx_valid_i,
   input  logic [7:0]           exp_tx_data_i,
   input  logic                 exp_rx_valid_i,
   input  logic [7:0]           exp_rx_data_i,
   input  int                   test_id_i,
   input  logic                 test_done_i,
   input  logic                 all_done_i,
   input  int                   misc_errs_i,
   output int                   err_count_o
);

   logic [7:0] tx_q[$];
   logic [7:0] rx_q[$];
   string      names[6] = '{"reset_idle", "transmit", "receive_read",
                            "flow_control", "start_glitch", "soft_reset"};
   int         errs = 0;
   int         test_errs = 0;
   int         tests = 0;
   int         cnt = 0;        // cycles since start edge, 0 when idle
   int         bd;
   logic [7:0] sh;
   logic       rdy_d = 1'b0;
   logic       read_d = 1'b0;
   logic       srst_d = 1'b0;
   logic       rts_exp = 1'b0; // receiver has run since the last reset

   assign err_count_o = errs + test_errs + misc_errs_i;

   task automatic check_val(input logic [7:0] exp, input logic [7:0] act);
      if (exp !== act) begin
         $display("[FAIL] %s: expected %02h, actual %02h", names[test_id_i], exp, act);
         test_errs++;
      end
   endtask

   task automatic complain(input string what);
      $display("test %s: %s", names[test_id_i], what);
      test_errs++;
   endtask

   always @(posedge clk_i) begin
      bd = int'(ctrl_i.bit_duration);
      if (arst_n_i) begin
         if (exp_tx_valid_i) tx_q.push_back(exp_tx_data_i);
         if (exp_rx_valid_i) rx_q.push_back(exp_rx_data_i);
         //////////////////////////////
         // txd frame decoder, samples at mid-bit
         //////////////////////////////
         if (ctrl_i.soft_rst) begin
            cnt = 0;                     // frame in flight is dropped
            tx_q.delete();
         end else if (cnt == 0) begin
            if (!pins_i.txd) cnt = 1;
         end else begin
            cnt++;
            if (cnt == bd / 2 && pins_i.txd) begin
               complain("start bit not low at mid-bit");
               cnt = 0;
            end else if (cnt > bd / 2 && cnt < bd / 2 + 9 * bd && cnt % bd == bd / 2) begin
               sh = {pins_i.txd, sh[7:1]};   // lsb first
            end else if (cnt == bd / 2 + 9 * bd) begin
               if (!pins_i.txd) complain("stop bit not high");
               if (tx_q.size() == 0) complain("frame sent without a write");
               else check_val(tx_q.pop_front(), sh);
               cnt = 0;
            end
         end
         // receive side
         if (rx_ready_i && !rdy_d) begin
            if (rx_q.size() == 0) complain("byte received with none sent");
            else check_val(rx_q.pop_front(), rx_data_i);
         end
         if (read_d && rx_ready_i) complain("rx_ready still high after read");
         if (pins_i.rts !== rts_exp) begin
            $display("[FAIL] %s: rts expected %b, actual %b",
                     names[test_id_i], rts_exp, pins_i.rts);
            test_errs++;
         end
         if (srst_d && (!pins_i.txd || tx_ready_i)) complain("soft reset left line busy");
         if (test_id_i == 0) begin
            if (!pins_i.txd) complain("txd low while idle");
            if (rx_ready_i) complain("rx_ready high with no frame");
            if (!ctrl_i.tx_en && tx_ready_i) complain("tx_ready high while disabled");
         end
         if (test_id_i == 3 && !rs232_cts_i && !pins_i.txd) complain("start bit sent with cts low");
         if (test_done_i) begin
            if (tx_q.size() != 0 || rx_q.size() != 0) complain("expected frames never seen");
            $display("test %s finished, %0d errors", names[test_id_i], test_errs);
            errs += test_errs;
            test_errs = 0;
            tests++;
         end
         if (all_done_i) $display("tests run %0d, errors %0d", tests, errs + misc_errs_i);
      end
      if (!arst_n_i || ctrl_i.soft_rst) begin
         rts_exp = 1'b0;                 // low until the receiver runs
      end else if (ctrl_i.rx_en) begin
         rts_exp = 1'b1;
      end
      rdy_d  = rx_ready_i;
      read_d = data_read_en_i;
      srst_d = ctrl_i.soft_rst;
   end

endmodule

// ==== uart_consts.svh ====
//////////////////////////////
// widths and synchronizer depth of the uart core
// include before any module or package that sizes a signal
//////////////////////////////
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

//////////////////////////////
// data and timer widths
//////////////////////////////
`define UART_DATA_W 8                      // one data byte
`define UART_DIV_W 16                      // bit timer and bit_duration
`define UART_FRAME_W (`UART_DATA_W + 2)    // start + data + stop
`define UART_BITCNT_W 4                    // counts up to a full frame

//////////////////////////////
// input synchronizers
//////////////////////////////
`define UART_SYNC_STAGES 2                 // flops per async input

`endif

// ==== uart_core.sv ====
//////////////////////////////
// uart core top, transmitter and receiver with their bit timers
//////////////////////////////
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_core (
   input  logic                    clk_i,
   input  logic                    arst_n_i,
   input  uart_pkg::uart_ctrl_t    ctrl_i,
   input  logic [`UART_DATA_W-1:0] tx_data_i,
   input  logic                    data_write_en_i,
   input  logic                    data_read_en_i,
   input  logic                    rs232_rxd_i,
   input  logic                    rs232_cts_i,
   output logic [`UART_DATA_W-1:0] rx_data_o,
   output logic                    tx_ready_o,
   output logic                    rx_ready_o,
   output uart_pkg::uart_pins_t    pins_o
);

   import uart_pkg::*;

   timer_ctl_t tx_tmr;
   timer_ctl_t rx_tmr;
   logic       tx_bit_done;
   logic       rx_bit_done;
   logic       rx_half_done;
   logic       txd;
   logic       rts;

   //////////////////////////////
   // transmit path
   //////////////////////////////
   uart_tx u_tx (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .ctrl_i         (ctrl_i),
      .tx_data_i      (tx_data_i),
      .data_write_en_i(data_write_en_i),
      .rs232_cts_i    (rs232_cts_i),
      .bit_done_i     (tx_bit_done),
      .timer_o        (tx_tmr),
      .tx_ready_o     (tx_ready_o),
      .txd_o          (txd)
   );

   uart_bit_timer tx_timer (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .soft_rst_i    (ctrl_i.soft_rst),
      .ctl_i         (tx_tmr),
      .bit_duration_i(ctrl_i.bit_duration),
      .bit_done_o    (tx_bit_done),
      .half_done_o   ()               // tx has no half-bit point
   );

   //////////////////////////////
   // receive path
   //////////////////////////////
   uart_rx u_rx (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .ctrl_i        (ctrl_i),
      .data_read_en_i(data_read_en_i),
      .rs232_rxd_i   (rs232_rxd_i),
      .bit_done_i    (rx_bit_done),
      .half_done_i   (rx_half_done),
      .timer_o       (rx_tmr),
      .rx_data_o     (rx_data_o),
      .rx_ready_o    (rx_ready_o),
      .rts_o         (rts)
   );

   uart_bit_timer rx_timer (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .soft_rst_i    (ctrl_i.soft_rst),
      .ctl_i         (rx_tmr),
      .bit_duration_i(ctrl_i.bit_duration),
      .bit_done_o    (rx_bit_done),
      .half_done_o   (rx_half_done)
   );

   assign pins_o = '{txd: txd, rts: rts};

endmodule

// ==== uart_pkg.sv ====
//////////////////////////////
// state enums and packed structs shared by the uart RTL and testbench
//////////////////////////////
`include "uart_consts.svh"

package uart_pkg;

   //////////////////////////////
   // state machines
   //////////////////////////////
   typedef enum logic [1:0] {
      TX_IDLE,    // waiting for a write
      TX_LOAD,    // frame pattern built here
      TX_SEND     // shifting the frame out
   } tx_state_e;

   typedef enum logic [2:0] {
      RX_SYNC,        // wait for a high line
      RX_IDLE_HIGH,   // line must stay high one bit
      RX_WAIT_START,  // wait for the falling edge
      RX_START,       // confirm start at half bit
      RX_DATA         // eight samples, lsb first
   } rx_state_e;

   //////////////////////////////
   // grouped signals
   //////////////////////////////
   typedef struct packed {
      logic                   soft_rst;      // sync clear, both directions
      logic                   tx_en;
      logic                   rx_en;
      logic [`UART_DIV_W-1:0] bit_duration;  // clock cycles per bit
   } uart_ctrl_t;

   typedef struct packed {
      logic txd;
      logic rts;
   } uart_pins_t;

   typedef struct packed {
      logic clr;  // count restarts at 1
      logic run;  // count advances
   } timer_ctl_t;

endpackage

// ==== uart_props.sv ====
//////////////////////////////
// assertions on the uart frame and ready levels, bound to uart_core
//////////////////////////////
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_props (
   input logic                 clk_i,
   input logic                 arst_n_i,
   input uart_pkg::uart_ctrl_t ctrl_i,
   input logic                 data_read_en_i,
   input logic                 tx_ready_o,
   input logic                 rx_ready_o,
   input uart_pkg::uart_pins_t pins_o
);

   logic [`UART_DIV_W-1:0] start_cnt;  // cycles into the start bit

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         start_cnt <= '0;
      end else if (ctrl_i.soft_rst) begin
         start_cnt <= '0;
      end else if ($fell(pins_o.txd)) begin
         start_cnt <= `UART_DIV_W'(1);
      end else if (start_cnt != '0 && start_cnt < ctrl_i.bit_duration - `UART_DIV_W'(1)) begin
         start_cnt <= start_cnt + `UART_DIV_W'(1);
      end else begin
         start_cnt <= '0;
      end
   end

   // ready is only high in the idle state
   idle_line_high: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tx_ready_o |-> pins_o.txd) else $error("txd low while transmitter idle");

   read_clears_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      data_read_en_i |=> !rx_ready_o) else $error("rx_ready high after read strobe");

   start_bit_low: assert property (@(posedge clk_i) disable iff (!arst_n_i || ctrl_i.soft_rst)
      ($fell(pins_o.txd) || start_cnt != '0) |-> !pins_o.txd)
      else $error("start bit shorter than bit_duration");

endmodule

bind uart_core uart_props u_props (
   .clk_i         (clk_i),
   .arst_n_i      (arst_n_i),
   .ctrl_i        (ctrl_i),
   .data_read_en_i(data_read_en_i),
   .tx_ready_o    (tx_ready_o),
   .rx_ready_o    (rx_ready_o),
   .pins_o        (pins_o)
);

// ==== uart_rx.sv ====
//////////////////////////////
// uart receiver, samples 8N1 frames at mid-bit
// drives rts and flags each byte with rx_ready
//////////////////////////////
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_rx (
   input  logic                    clk_i,
   input  logic                    arst_n_i,
   input  uart_pkg::uart_ctrl_t    ctrl_i,
   input  logic                    data_read_en_i,
   input  logic                    rs232_rxd_i,
   input  logic                    bit_done_i,
   input  logic                    half_done_i,
   output uart_pkg::timer_ctl_t    timer_o,
   output logic [`UART_DATA_W-1:0] rx_data_o,
   output logic                    rx_ready_o,
   output logic                    rts_o
);

   import uart_pkg::*;

   logic [`UART_SYNC_STAGES-1:0] rxd_sync_q;
   logic                         rxd_s;
   logic                         rxd_prev_q;
   logic                         rx_run;
   rx_state_e                    state_q, state_n;
   logic [`UART_DATA_W-1:0]      shift_q, shift_n;
   logic [`UART_DATA_W-1:0]      data_n;
   logic [`UART_BITCNT_W-1:0]    bitcnt_q, bitcnt_n;
   logic                         ready_n;
   timer_ctl_t                   tmr_n;

   //////////////////////////////
   // rxd synchronizer
   //////////////////////////////
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rxd_sync_q <= '1;                   // idle line is high
         rxd_prev_q <= 1'b1;
      end else begin
         rxd_sync_q <= {rxd_sync_q[`UART_SYNC_STAGES-2:0], rs232_rxd_i};
         rxd_prev_q <= rxd_s;                // for the falling edge
      end
   end

   assign rxd_s  = rxd_sync_q[`UART_SYNC_STAGES-1];
   assign rx_run = ctrl_i.rx_en;

   //////////////////////////////
   // fsm and sampling shifter
   //////////////////////////////
   always_comb begin
      state_n  = state_q;
      shift_n  = shift_q;
      data_n   = rx_data_o;
      bitcnt_n = bitcnt_q;
      ready_n  = rx_ready_o;
      tmr_n    = '0;
      case (state_q)
         RX_SYNC: begin
            tmr_n.clr = 1'b1;
            bitcnt_n  = '0;
            if (rxd_s) begin
               state_n = RX_IDLE_HIGH;
            end
         end
         RX_IDLE_HIGH: begin
            tmr_n.run = 1'b1;
            if (!rxd_s) begin
               state_n = RX_SYNC;            // dropped early, resync
            end else if (bit_done_i) begin
               state_n = RX_WAIT_START;
            end
         end
         RX_WAIT_START: begin
            tmr_n.clr = 1'b1;
            // an edge, so a low last data bit is not taken as a start
            if (!rxd_s && rxd_prev_q) begin
               state_n = RX_START;
            end
         end
         RX_START: begin
            if (!half_done_i) begin
               tmr_n.run = 1'b1;
            end else begin
               tmr_n.clr = 1'b1;             // data bits now timed from mid-start
               state_n   = rxd_s ? RX_SYNC : RX_DATA;
            end
         end
         RX_DATA: begin
            if (!bit_done_i) begin
               tmr_n.run = 1'b1;
            end else begin
               tmr_n.clr = 1'b1;
               shift_n   = {rxd_s, shift_q[`UART_DATA_W-1:1]};  // lsb first
               if (bitcnt_q == `UART_BITCNT_W'(`UART_DATA_W - 1)) begin
                  data_n   = shift_n;
                  ready_n  = 1'b1;
                  bitcnt_n = '0;
                  state_n  = RX_WAIT_START;
               end else begin
                  bitcnt_n = bitcnt_q + `UART_BITCNT_W'(1);
               end
            end
         end
         default: state_n = RX_SYNC;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q  <= RX_SYNC;
         bitcnt_q <= '0;
      end else if (ctrl_i.soft_rst) begin
         state_q  <= RX_SYNC;
         bitcnt_q <= '0;
      end else if (rx_run) begin
         state_q  <= state_n;
         bitcnt_q <= bitcnt_n;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rx_run) begin
         shift_q   <= shift_n;
         rx_data_o <= data_n;                // holds until the next frame
      end
   end

   //////////////////////////////
   // ready flag and rts
   //////////////////////////////
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rx_ready_o <= 1'b0;
      end else if (ctrl_i.soft_rst || data_read_en_i) begin
         rx_ready_o <= 1'b0;                 // read wins over a new byte
      end else if (rx_run) begin
         rx_ready_o <= ready_n;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rts_o <= 1'b0;
      end else if (ctrl_i.soft_rst) begin
         rts_o <= 1'b0;
      end else if (rx_run) begin
         rts_o <= 1'b1;                      // ready to take data
      end
   end

   assign timer_o = '{clr: tmr_n.clr & rx_run, run: tmr_n.run & rx_run};

endmodule

// ==== uart_tx.sv ====
//////////////////////////////
// uart transmitter, 8N1 frames shifted out lsb first
// stalls while tx_en or the synchronized cts is low
//////////////////////////////
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_tx (
   input  logic                    clk_i,
   input  logic                    arst_n_i,
   input  uart_pkg::uart_ctrl_t    ctrl_i,
   input  logic [`UART_DATA_W-1:0] tx_data_i,
   input  logic                    data_write_en_i,
   input  logic                    rs232_cts_i,
   input  logic                    bit_done_i,
   output uart_pkg::timer_ctl_t    timer_o,
   output logic                    tx_ready_o,
   output logic                    txd_o
);

   import uart_pkg::*;

   logic [`UART_SYNC_STAGES-1:0] cts_sync_q;
   logic                         tx_run;
   logic [`UART_DATA_W-1:0]      tx_hold_q;
   logic                         write_pend_q;
   logic                         start;
   tx_state_e                    state_q, state_n;
   logic [`UART_FRAME_W-1:0]     pattern_q, pattern_n;
   logic [`UART_BITCNT_W-1:0]    bitcnt_q, bitcnt_n;
   logic                         ready_n;
   timer_ctl_t                   tmr_n;

   //////////////////////////////
   // cts synchronizer
   //////////////////////////////
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cts_sync_q <= '0;
      end else begin
         cts_sync_q <= {cts_sync_q[`UART_SYNC_STAGES-2:0], rs232_cts_i};
      end
   end

   assign tx_run = ctrl_i.tx_en & cts_sync_q[`UART_SYNC_STAGES-1];

   // every write lands here, even while busy
   always_ff @(posedge clk_i) begin
      if (data_write_en_i) begin
         tx_hold_q <= tx_data_i;
      end
   end

   // write accepted while stalled, started once the line may send
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         write_pend_q <= 1'b0;
      end else if (ctrl_i.soft_rst) begin
         write_pend_q <= 1'b0;
      end else if (tx_run && state_q == TX_IDLE) begin
         write_pend_q <= 1'b0;               // consumed by the fsm
      end else if (data_write_en_i && tx_ready_o) begin
         write_pend_q <= 1'b1;
      end
   end

   assign start = write_pend_q | (data_write_en_i & tx_ready_o);

   //////////////////////////////
   // fsm and frame shifter
   //////////////////////////////
   always_comb begin
      state_n   = state_q;
      pattern_n = pattern_q;
      bitcnt_n  = bitcnt_q;
      ready_n   = tx_ready_o;
      tmr_n     = '0;
      case (state_q)
         TX_IDLE: begin
            tmr_n.clr = 1'b1;
            pattern_n = '1;                  // line idles high
            bitcnt_n  = '0;
            ready_n   = 1'b1;
            if (start) begin
               ready_n = 1'b0;
               state_n = TX_LOAD;
            end
         end
         TX_LOAD: begin
            tmr_n.clr = 1'b1;
            pattern_n = {1'b1, tx_hold_q, 1'b0};  // {stop, data, start}
            state_n   = TX_SEND;
         end
         TX_SEND: begin
            if (!bit_done_i) begin
               tmr_n.run = 1'b1;
            end else begin
               tmr_n.clr = 1'b1;
               if (bitcnt_q == `UART_BITCNT_W'(`UART_FRAME_W - 1)) begin
                  state_n = TX_IDLE;         // stop bit done
                  ready_n = 1'b1;
               end else begin
                  pattern_n = {1'b1, pattern_q[`UART_FRAME_W-1:1]};
                  bitcnt_n  = bitcnt_q + `UART_BITCNT_W'(1);
               end
            end
         end
         default: state_n = TX_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= TX_IDLE;
         pattern_q  <= '1;
         bitcnt_q   <= '0;
         tx_ready_o <= 1'b0;
      end else if (ctrl_i.soft_rst) begin
         state_q    <= TX_IDLE;
         pattern_q  <= '1;
         bitcnt_q   <= '0;
         tx_ready_o <= 1'b0;
      end else if (tx_run) begin             // frozen under back-pressure
         state_q    <= state_n;
         pattern_q  <= pattern_n;
         bitcnt_q   <= bitcnt_n;
         tx_ready_o <= ready_n;
      end
   end

   assign timer_o = '{clr: tmr_n.clr & tx_run, run: tmr_n.run & tx_run};
   assign txd_o   = pattern_q[0];

endmodule
